//--- common/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int WORD_W = 32;                 // instruction and pc width

    typedef logic [WORD_W-1:0] word_t;          // instruction or data word
    typedef logic [WORD_W-1:0] pc_t;            // byte address
    typedef logic [7:0]        byte_t;          // one load byte

    // all-zero word, shared by cleared memory, held fetch and flush bubbles
    localparam word_t NOP_WORD = '0;

endpackage : fetch_pkg

`default_nettype wire

//--- common/if_id_if.sv
`timescale 1ns/1ns
`default_nettype none

interface if_id_if;
    import fetch_pkg::*;

    logic  valid;                               // fetch slot holds a real instr
    pc_t   pc;                                  // address of instr
    pc_t   pc_plus4;                            // sequential successor
    word_t instr;                               // fetched word

    modport source (
        output valid,
        output pc,
        output pc_plus4,
        output instr
    );

    modport sink (
        input valid,
        input pc,
        input pc_plus4,
        input instr
    );

endinterface : if_id_if

`default_nettype wire

//--- rtl/instruction_fetch/instr_mem.sv
`timescale 1ns/1ns
`default_nettype none

module instr_mem #(
    parameter  int MEM_DEPTH = 64,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_wr_en,        // loader write strobe
    input  logic [ADDR_W-1:0]   i_wr_addr,      // word index
    input  fetch_pkg::word_t    i_wr_data,
    input  logic [ADDR_W-1:0]   i_rd_addr,      // word index from pc
    output fetch_pkg::word_t    o_rd_data
);
    import fetch_pkg::*;

    word_t mem [MEM_DEPTH];                     // program storage

    // whole array goes back to nop on reset, otherwise one word per edge
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= NOP_WORD;             // clear every slot
            end
        end else if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;        // loader write
        end
    end

    assign o_rd_data = mem[i_rd_addr];          // async read, same cycle as pc

endmodule : instr_mem

`default_nettype wire

//--- rtl/instruction_fetch/instruction_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module instruction_fetch #(
    parameter  int MEM_DEPTH = 64,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_stall,        // hold pc, from hazard unit
    input  logic                i_loading,      // loader owns memory
    input  logic                i_branch_taken, // redirect request from decode
    input  fetch_pkg::pc_t      i_branch_target,
    input  logic                i_wr_en,        // loader write port
    input  logic [ADDR_W-1:0]   i_wr_addr,
    input  fetch_pkg::word_t    i_wr_data,
    if_id_if.source             o_fetch         // bundle toward IF/ID
);
    import fetch_pkg::*;

    localparam pc_t LAST_PC = pc_t'((MEM_DEPTH - 1) * 4); // byte addr of last word

    pc_t              pc;                       // current fetch address
    pc_t              pc_plus4;                 // adder output
    pc_t              pc_next;                  // selected next pc
    logic [ADDR_W-1:0] rd_addr;                 // word index into memory
    word_t            rd_data;                  // raw memory word

    assign pc_plus4 = pc + pc_t'(4);            // sequential adder
    assign rd_addr  = pc[ADDR_W+1:2];           // drop byte offset

    // next pc priority: loading, stall, branch, wrap, sequential
    always_comb begin
        if (i_loading) begin
            pc_next = '0;                       // park at 0 while loading
        end else if (i_stall) begin
            pc_next = pc;                       // stall wins over branch
        end else if (i_branch_taken) begin
            pc_next = i_branch_target;          // redirect
        end else if (pc == LAST_PC) begin
            pc_next = '0;                       // wrap after last word
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    instr_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_instr_mem (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    assign o_fetch.valid    = ~i_loading;       // nothing real while loading
    assign o_fetch.pc       = pc;
    assign o_fetch.pc_plus4 = pc_plus4;
    assign o_fetch.instr    = i_loading ? NOP_WORD : rd_data; // zero during writes

    // branch targets from decode must keep the pc on a word boundary
    a_pc_aligned : assert property (
        @(posedge i_clk) disable iff (i_rst)
        pc[1:0] == 2'b00
    ) else $error("instruction_fetch: pc not word aligned");

endmodule : instruction_fetch

`default_nettype wire

//--- rtl/program_loader.sv
`timescale 1ns/1ns
`default_nettype none

module program_loader #(
    parameter  int MEM_DEPTH = 64,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_load_en,      // level, loader active
    input  logic                i_load_strobe,  // one byte per strobe
    input  fetch_pkg::byte_t    i_load_byte,
    output logic                o_wr_en,
    output logic [ADDR_W-1:0]   o_wr_addr,
    output fetch_pkg::word_t    o_wr_data,
    output logic                o_loading
);
    import fetch_pkg::*;

    localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(MEM_DEPTH - 1);

    logic              load_en_q;               // for rise detect
    logic              load_start;              // first cycle of a load
    logic [1:0]        byte_cnt;                // bytes in current word
    logic [1:0]        cnt_cur;                 // count after start clear
    logic [ADDR_W-1:0] word_addr;               // next word slot
    logic [ADDR_W-1:0] addr_cur;
    logic              full;                    // last slot written
    logic              full_cur;
    logic              accept;                  // byte taken this cycle
    logic              word_done;               // fourth byte taken
    logic              wr_pending;              // write next cycle
    logic [ADDR_W-1:0] wr_addr_q;               // slot of pending write
    word_t             word_sr;                 // byte shift register

    assign load_start = i_load_en & ~load_en_q;

    // counters restart on the rising edge of load_en, same-cycle strobe included
    assign cnt_cur   = load_start ? 2'd0 : byte_cnt;
    assign addr_cur  = load_start ? '0 : word_addr;
    assign full_cur  = load_start ? 1'b0 : full;
    assign accept    = i_load_en & i_load_strobe & ~full_cur;
    assign word_done = accept & (cnt_cur == 2'd3);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            load_en_q  <= 1'b0;
            byte_cnt   <= '0;
            word_addr  <= '0;
            full       <= 1'b0;
            wr_pending <= 1'b0;
        end else begin
            load_en_q  <= i_load_en;
            wr_pending <= word_done;            // write lands one cycle later
            byte_cnt   <= accept ? cnt_cur + 2'd1 : cnt_cur; // wraps at 4
            full       <= full_cur | (word_done & (addr_cur == LAST_ADDR));
            if (word_done && addr_cur != LAST_ADDR) begin
                word_addr <= addr_cur + 1'b1;
            end else begin
                word_addr <= addr_cur;          // sticks at last slot
            end
        end
    end

    // little-endian packing, first byte ends in bits 7:0
    always_ff @(posedge i_clk) begin
        if (accept) begin
            word_sr <= {i_load_byte, word_sr[WORD_W-1:8]};
        end
        if (word_done) begin
            wr_addr_q <= addr_cur;              // slot for this word
        end
    end

    assign o_wr_en   = wr_pending;
    assign o_wr_addr = wr_addr_q;
    assign o_wr_data = word_sr;                 // complete until next strobe edge
    assign o_loading = i_load_en;

    // load_en has to stay up for the write that follows the last byte
    a_no_write_idle : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_wr_en |-> i_load_en
    ) else $error("program_loader: write with load_en low");

endmodule : program_loader

`default_nettype wire

//--- rtl/if_id_reg.sv
`timescale 1ns/1ns
`default_nettype none

module if_id_reg (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_stall,           // hold contents
    input  logic             i_flush,           // squash slot fetched this cycle
    if_id_if.sink            i_fetch,           // bundle from fetch stage
    output logic             o_valid,
    output fetch_pkg::pc_t   o_pc,
    output fetch_pkg::pc_t   o_pc_plus4,
    output fetch_pkg::word_t o_instr
);
    import fetch_pkg::*;

    // valid is control, pc and instr are payload
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (!i_stall) begin
            o_valid <= i_fetch.valid & ~i_flush; // bubble on flush
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_stall) begin
            o_pc       <= i_fetch.pc;
            o_pc_plus4 <= i_fetch.pc_plus4;
            if (i_flush) begin
                o_instr <= NOP_WORD;            // squashed slot
            end else begin
                o_instr <= i_fetch.instr;
            end
        end
    end

    // a branch seen by decode must leave a bubble behind it
    a_flush_bubble : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_flush && !i_stall) |=> !o_valid
    ) else $error("if_id_reg: valid after unstalled flush");

endmodule : if_id_reg

`default_nettype wire

//--- rtl/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
    parameter  int MEM_DEPTH = 64,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_load_en,         // loader owns memory
    input  logic             i_load_strobe,
    input  fetch_pkg::byte_t i_load_byte,
    input  logic             i_stall,           // from hazard unit
    input  logic             i_branch_taken,    // from decode
    input  fetch_pkg::pc_t   i_branch_target,
    output logic             o_loading,
    output logic             o_id_valid,
    output fetch_pkg::pc_t   o_id_pc,
    output fetch_pkg::pc_t   o_id_pc_plus4,
    output fetch_pkg::word_t o_id_instr
);
    import fetch_pkg::*;

    logic              wr_en;                   // loader to memory
    logic [ADDR_W-1:0] wr_addr;
    word_t             wr_data;
    logic              loading;                 // load level into fetch

    if_id_if fetch_bus ();                      // fetch stage to IF/ID

    program_loader #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_loader (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_load_en     (i_load_en),
        .i_load_strobe (i_load_strobe),
        .i_load_byte   (i_load_byte),
        .o_wr_en       (wr_en),
        .o_wr_addr     (wr_addr),
        .o_wr_data     (wr_data),
        .o_loading     (loading)
    );

    assign o_loading = loading;

    instruction_fetch #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_stall         (i_stall),
        .i_loading       (loading),
        .i_branch_taken  (i_branch_taken),
        .i_branch_target (i_branch_target),
        .i_wr_en         (wr_en),
        .i_wr_addr       (wr_addr),
        .i_wr_data       (wr_data),
        .o_fetch         (fetch_bus.source)
    );

    if_id_reg u_if_id (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_stall    (i_stall),
        .i_flush    (i_branch_taken),           // taken branch squashes next slot
        .i_fetch    (fetch_bus.sink),
        .o_valid    (o_id_valid),
        .o_pc       (o_id_pc),
        .o_pc_plus4 (o_id_pc_plus4),
        .o_instr    (o_id_instr)
    );

endmodule : fetch_top

`default_nettype wire

//--- tb/fetch_checker.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_checker #(
    parameter  int MEM_DEPTH = 64,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_load_en,
    input  logic             i_load_strobe,
    input  fetch_pkg::byte_t i_load_byte,
    input  logic             i_stall,
    input  logic             i_branch_taken,
    input  fetch_pkg::pc_t   i_branch_target,
    input  logic             i_loading,
    input  logic             i_id_valid,
    input  fetch_pkg::pc_t   i_id_pc,
    input  fetch_pkg::pc_t   i_id_pc_plus4,
    input  fetch_pkg::word_t i_id_instr,
    output int               o_checks,
    output int               o_mismatches,
    output int               o_wraps
);
    import fetch_pkg::*;

    localparam pc_t SPAN = pc_t'(MEM_DEPTH * 4); // bytes covered by memory

    int    checks     = 0;
    int    mismatches = 0;
    int    wraps      = 0;
    logic  armed      = 1'b0;                   // set once reset was seen
    logic  exp_known  = 1'b0;                   // id outputs defined
    logic  exp_valid  = 1'b0;
    pc_t   exp_pc     = '0;
    word_t exp_instr  = '0;
    pc_t   ref_pc     = '0;                     // modelled fetch pc
    pc_t   prev_pc    = '0;                     // last valid id pc
    logic  prev_valid = 1'b0;

    assign o_checks     = checks;
    assign o_mismatches = mismatches;
    assign o_wraps      = wraps;

    // loading, then stall, then branch, then sequential with wrap
    function automatic pc_t ref_next_pc(input pc_t pc, input logic load, input logic hold,
                                        input logic br, input pc_t tgt);
        if (load) return '0;
        if (hold) return pc;
        if (br) return tgt;
        return (pc + pc_t'(4)) % SPAN;
    endfunction

    function automatic word_t ref_instr(input pc_t pc, input logic load, input logic br);
        if (load || br) return NOP_WORD;        // blanked or flushed
        return fetch_tb.prog[pc[ADDR_W+1:2]];   // word index
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            mismatches++;
            $display("Error %s %s: expected %h, actual %h", fetch_tb.test_name, what, exp, act);
        end
    endtask

    // negedge, inputs and outputs settled since the last rising edge
    always @(negedge i_clk) begin
        compare("o_loading", 32'(i_load_en), 32'(i_loading));
        if (armed) begin
            compare("o_id_valid", 32'(exp_valid), 32'(i_id_valid));
            if (exp_known) begin
                compare("o_id_instr", exp_instr, i_id_instr);
            end
            if (exp_valid) begin
                compare("o_id_pc", exp_pc, i_id_pc);
                compare("o_id_pc_plus4", exp_pc + pc_t'(4), i_id_pc_plus4);
            end
        end
        if (i_id_valid === 1'b1) begin
            if (prev_valid && prev_pc == SPAN - pc_t'(4) && i_id_pc == '0) begin
                wraps++;                        // last word followed by word 0
            end
            prev_pc = i_id_pc;
        end
        prev_valid = (i_id_valid === 1'b1);

        // expected state after the coming rising edge
        if (i_rst) begin
            armed     = 1'b1;
            exp_known = 1'b0;
            exp_valid = 1'b0;
            ref_pc    = '0;
        end else if (armed) begin
            if (!i_stall) begin                 // id register captures
                exp_valid = !i_load_en && !i_branch_taken;
                exp_pc    = ref_pc;
                exp_instr = ref_instr(ref_pc, i_load_en, i_branch_taken);
                exp_known = 1'b1;
            end
            ref_pc = ref_next_pc(ref_pc, i_load_en, i_stall, i_branch_taken, i_branch_target);
        end
    end

endmodule : fetch_checker

`default_nettype wire

//--- tb/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int MEM_DEPTH = 64;
    localparam int WAIT_MAX  = 20;              // cycles before a wait gives up

    logic  clk;
    logic  rst;
    logic  load_en;
    logic  load_strobe;
    byte_t load_byte;
    logic  stall;
    logic  branch_taken;
    pc_t   branch_target;
    logic  loading;
    logic  id_valid;
    pc_t   id_pc;
    pc_t   id_pc_plus4;
    word_t id_instr;

    word_t       prog [MEM_DEPTH];              // image of what memory should hold
    string       test_name;                     // shown in error lines
    logic [31:0] rng;                           // xorshift state
    int          other_fails;                   // timeouts and missing events
    int          checks;
    int          mismatches;
    int          wraps;

    fetch_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) dut0 (
        .i_clk           (clk),
        .i_rst           (rst),
        .i_load_en       (load_en),
        .i_load_strobe   (load_strobe),
        .i_load_byte     (load_byte),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_loading       (loading),
        .o_id_valid      (id_valid),
        .o_id_pc         (id_pc),
        .o_id_pc_plus4   (id_pc_plus4),
        .o_id_instr      (id_instr)
    );

    fetch_checker #(
        .MEM_DEPTH (MEM_DEPTH)
    ) chk0 (
        .i_clk           (clk),
        .i_rst           (rst),
        .i_load_en       (load_en),
        .i_load_strobe   (load_strobe),
        .i_load_byte     (load_byte),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .i_loading       (loading),
        .i_id_valid      (id_valid),
        .i_id_pc         (id_pc),
        .i_id_pc_plus4   (id_pc_plus4),
        .i_id_instr      (id_instr),
        .o_checks        (checks),
        .o_mismatches    (mismatches),
        .o_wraps         (wraps)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);                  // advance shared state
        return rng;
    endfunction

    function automatic pc_t rand_target();
        return pc_t'((next_rand() % 32'(MEM_DEPTH)) << 2); // aligned and inside memory
    endfunction

    task automatic run_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_loading_high();
        int n;
        n = 0;
        @(negedge clk);
        while (loading !== 1'b1 && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (loading !== 1'b1) begin
            $display("timeout in %s: o_loading never went high", test_name);
            other_fails++;
        end
    endtask

    task automatic wait_valid_level(input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while (id_valid !== level && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (id_valid !== level) begin
            $display("timeout in %s: o_id_valid never reached %b", test_name, level);
            other_fails++;
        end
    endtask

    // new random image, streamed lowest byte first with random gaps
    task automatic load_program();
        int gap;
        @(posedge clk);
        load_en <= 1'b1;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            prog[i] = next_rand();              // fetch is blanked while loading
        end
        wait_loading_high();
        wait_valid_level(1'b0);                 // fetch must go quiet
        for (int i = 0; i < MEM_DEPTH; i++) begin
            for (int b = 0; b < 4; b++) begin
                @(posedge clk);
                load_strobe <= 1'b1;
                load_byte   <= prog[i][8*b +: 8];
                @(posedge clk);
                load_strobe <= 1'b0;
                gap = int'(next_rand() % 32'd3);
                repeat (gap) @(posedge clk);
            end
        end
        repeat (3) @(posedge clk);              // last write lands before release
        load_en <= 1'b0;
    endtask

    task automatic branch_to(input pc_t target, input logic with_stall);
        @(posedge clk);
        branch_taken  <= 1'b1;
        branch_target <= target;
        stall         <= with_stall;
        @(posedge clk);
        branch_taken  <= 1'b0;
        stall         <= 1'b0;
    endtask

    initial begin
        rng           = 32'h0893e1ff;
        rst           = 1'b1;
        load_en       = 1'b0;
        load_strobe   = 1'b0;
        load_byte     = '0;
        stall         = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        other_fails   = 0;
        test_name     = "reset";
        for (int i = 0; i < MEM_DEPTH; i++) begin
            prog[i] = NOP_WORD;                 // memory is cleared by reset
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        run_cycles(6);                          // unloaded memory reads zero

        test_name = "load_seq";
        load_program();
        wait_valid_level(1'b1);
        run_cycles(2 * MEM_DEPTH + 8);          // enough for one full wrap
        if (wraps == 0) begin
            $display("no wrap from the last word back to pc 0 was seen");
            other_fails++;
        end

        test_name = "branch";
        for (int k = 0; k < 6; k++) begin
            branch_to(rand_target(), 1'b0);
            run_cycles(3);
        end
        // second redirect arrives while the first target is being fetched
        @(posedge clk);
        branch_taken  <= 1'b1;
        branch_target <= rand_target();
        @(posedge clk);
        branch_target <= rand_target();         // back to back redirect
        @(posedge clk);
        branch_taken  <= 1'b0;
        run_cycles(4);

        test_name = "stall";
        for (int k = 0; k < 40; k++) begin
            @(posedge clk);
            stall         <= (next_rand() % 32'd3) == 32'd0;
            branch_taken  <= (next_rand() % 32'd8) == 32'd0;
            branch_target <= rand_target();
        end
        @(posedge clk);
        stall        <= 1'b0;
        branch_taken <= 1'b0;
        branch_to(rand_target(), 1'b1);         // dropped as decode re-presents it
        run_cycles(6);

        test_name = "reload";
        run_cycles(10);
        load_program();
        wait_valid_level(1'b1);
        run_cycles(MEM_DEPTH + 8);
        run_cycles(2);

        $display("checks %0d, mismatches %0d, other failures %0d",
                 checks, mismatches, other_fails);
        if (mismatches == 0 && other_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : fetch_tb

`default_nettype wire

//--- project.f
common/fetch_pkg.sv
common/if_id_if.sv
rtl/instruction_fetch/instr_mem.sv
rtl/instruction_fetch/instruction_fetch.sv
rtl/program_loader.sv
rtl/if_id_reg.sv
rtl/fetch_top.sv
tb/fetch_checker.sv
tb/fetch_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim)
echo "$out"

if echo "$out" | grep -q "^PASS: all tests$"; then
    exit 0
else
    exit 1
fi
